//--- include/ooo_defines.svh
/*
 * out-of-order back end constants
 */

`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

////////////////////////////////////////
// datapath
////////////////////////////////////////

// operand and result width
`define OOO_XLEN 32

// destination register count
`define OOO_ARCH_REGS 32

////////////////////////////////////////
// reorder buffer and lanes
////////////////////////////////////////

// entries, power of two so pointers wrap on their own
`define OOO_ROB_DEPTH 8

// multiply lane stages
`define OOO_MUL_LATENCY 3

`endif

//--- src/ooo_op_pkg.sv
/*
 * operation and datapath types
 */

`include "ooo_defines.svh"

package ooo_op_pkg;

	// one operand or result word
	typedef logic [`OOO_XLEN-1:0] xlen_t;

	// reorder buffer index
	typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_tag_t;

	// destination register index
	typedef logic [$clog2(`OOO_ARCH_REGS)-1:0] arch_reg_t;

	// pre-decoded op codes
	// codes 0 to 6 are legal, 7 traps
	typedef enum logic [2:0] {
		OP_ADD     = 3'd0,
		OP_SUB     = 3'd1,
		OP_AND     = 3'd2,
		OP_OR      = 3'd3,
		OP_XOR     = 3'd4,
		OP_MUL     = 3'd5,
		OP_HALT    = 3'd6,
		OP_ILLEGAL = 3'd7
	} op_code_t;

endpackage

//--- src/ooo_status_pkg.sv
/*
 * core status and handshake states
 */

package ooo_status_pkg;

	// sticky error status seen at the top level
	typedef enum logic [1:0] {
		NO_ERROR      = 2'd0,
		ILLEGAL_INST  = 2'd1,
		HALTED_ON_WFI = 2'd2
	} error_status_t;

	// four-phase receiver states
	typedef enum logic [1:0] {
		DISP_IDLE      = 2'd0,
		DISP_ACK       = 2'd1,
		DISP_WAIT_DROP = 2'd2
	} dispatch_state_t;

endpackage

//--- src/dispatch_if.sv
/*
 * dispatch bus
 */

interface dispatch_if;

	// one-cycle pulse per accepted op
	logic                 valid;
	ooo_op_pkg::op_code_t  op;
	ooo_op_pkg::arch_reg_t dest;
	ooo_op_pkg::xlen_t     src_a;
	ooo_op_pkg::xlen_t     src_b;
	// rob tail, allocated in the valid cycle
	ooo_op_pkg::rob_tag_t  tag;

	modport issuer (output valid, op, dest, src_a, src_b);

	modport lane (input valid, op, src_a, src_b, tag);

	modport allocator (input valid, op, dest, output tag);

endinterface

//--- src/writeback_if.sv
/*
 * common data bus port
 */

interface writeback_if;

	// one-cycle pulse, marks the entry done
	logic                 valid;
	ooo_op_pkg::rob_tag_t tag;
	ooo_op_pkg::xlen_t    data;
	// only the logic lane ever raises this
	logic                 illegal;

	modport producer (output valid, tag, data, illegal);

	modport consumer (input valid, tag, data, illegal);

endinterface

//--- src/dispatch_stage.sv
/*
 * dispatch stage
 */

module dispatch_stage (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic                  req,
	input  ooo_op_pkg::op_code_t  op,
	input  ooo_op_pkg::arch_reg_t dest,
	input  ooo_op_pkg::xlen_t     src_a,
	input  ooo_op_pkg::xlen_t     src_b,
	input  logic                  room,
	output logic                  ack,
	dispatch_if.issuer            disp
);

	ooo_status_pkg::dispatch_state_t state;
	ooo_status_pkg::dispatch_state_t state_next;
	logic                            accept;

	////////////////////////////////////////
	// four-phase handshake
	////////////////////////////////////////

	// take a request only with rob space left
	assign accept = (state == ooo_status_pkg::DISP_IDLE) && req && room;

	always_comb begin
		state_next = state;
		case (state)
			ooo_status_pkg::DISP_IDLE: begin
				if (accept) begin
					state_next = ooo_status_pkg::DISP_ACK;
				end
			end
			// issue cycle, req may already be gone
			ooo_status_pkg::DISP_ACK: begin
				if (req) begin
					state_next = ooo_status_pkg::DISP_WAIT_DROP;
				end else begin
					state_next = ooo_status_pkg::DISP_IDLE;
				end
			end
			ooo_status_pkg::DISP_WAIT_DROP: begin
				if (!req) begin
					state_next = ooo_status_pkg::DISP_IDLE;
				end
			end
			default: begin
				state_next = ooo_status_pkg::DISP_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= ooo_status_pkg::DISP_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// ack held from acceptance until req drops
	assign ack = (state != ooo_status_pkg::DISP_IDLE);

	// exactly one issue pulse per transfer
	assign disp.valid = (state == ooo_status_pkg::DISP_ACK);

	////////////////////////////////////////
	// operation capture
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (accept) begin
			disp.op    <= op;
			disp.dest  <= dest;
			disp.src_a <= src_a;
			disp.src_b <= src_b;
		end
	end

	// ack only follows a sampled request
	a_ack_after_req: assert property (
		@(posedge clock) disable iff (!rst_n)
		$rose(ack) |-> $past(req)
	);

endmodule

//--- src/execute_stage.sv
/*
 * execute stage, logic and multiply lanes
 */

`include "ooo_defines.svh"

module execute_stage (
	input  logic          clock,
	input  logic          rst_n,
	dispatch_if.lane      disp,
	writeback_if.producer wb_logic,
	writeback_if.producer wb_mul
);

	localparam int HALF = `OOO_XLEN / 2;
	localparam int LAT  = `OOO_MUL_LATENCY;

	// logic lane, one register stage
	logic                 logic_valid;
	ooo_op_pkg::op_code_t logic_op;
	ooo_op_pkg::rob_tag_t logic_tag;
	ooo_op_pkg::xlen_t    logic_a;
	ooo_op_pkg::xlen_t    logic_b;
	ooo_op_pkg::xlen_t    logic_result;

	// multiply lane shift pipeline
	logic [LAT-1:0]       mul_valid;
	ooo_op_pkg::rob_tag_t mul_tag [LAT];
	ooo_op_pkg::xlen_t    mul_data [1:LAT-1];
	// stage 0 partial products
	ooo_op_pkg::xlen_t    mul_lo;
	logic [HALF-1:0]      mul_hi;

	////////////////////////////////////////
	// lane valids
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			logic_valid <= 1'b0;
			mul_valid   <= '0;
		end else begin
			// halt and illegal ride the logic lane
			logic_valid <= disp.valid && (disp.op != ooo_op_pkg::OP_MUL);
			mul_valid   <= {mul_valid[LAT-2:0], disp.valid && (disp.op == ooo_op_pkg::OP_MUL)};
		end
	end

	////////////////////////////////////////
	// payload
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (disp.valid) begin
			logic_op  <= disp.op;
			logic_tag <= disp.tag;
			logic_a   <= disp.src_a;
			logic_b   <= disp.src_b;
		end
		// low half of b, then low half of a times high half of b
		mul_tag[0] <= disp.tag;
		mul_lo     <= disp.src_a * disp.src_b[HALF-1:0];
		mul_hi     <= disp.src_a[HALF-1:0] * disp.src_b[`OOO_XLEN-1:HALF];
		// sum the partials, upper bits fall off
		mul_tag[1]  <= mul_tag[0];
		mul_data[1] <= mul_lo + {mul_hi, {HALF{1'b0}}};
		for (int i = 2; i < LAT; i++) begin
			mul_tag[i]  <= mul_tag[i-1];
			mul_data[i] <= mul_data[i-1];
		end
	end

	////////////////////////////////////////
	// logic lane result
	////////////////////////////////////////

	always_comb begin
		case (logic_op)
			ooo_op_pkg::OP_ADD: logic_result = logic_a + logic_b;
			ooo_op_pkg::OP_SUB: logic_result = logic_a - logic_b;
			ooo_op_pkg::OP_AND: logic_result = logic_a & logic_b;
			ooo_op_pkg::OP_OR:  logic_result = logic_a | logic_b;
			ooo_op_pkg::OP_XOR: logic_result = logic_a ^ logic_b;
			// halt and illegal give zero
			default:            logic_result = '0;
		endcase
	end

	assign wb_logic.valid   = logic_valid;
	assign wb_logic.tag     = logic_tag;
	assign wb_logic.data    = logic_result;
	assign wb_logic.illegal = (logic_op == ooo_op_pkg::OP_ILLEGAL);

	// multiplies never trap
	assign wb_mul.valid   = mul_valid[LAT-1];
	assign wb_mul.tag     = mul_tag[LAT-1];
	assign wb_mul.data    = mul_data[LAT-1];
	assign wb_mul.illegal = 1'b0;

	// multiplies stay off the logic bus
	a_no_mul_on_logic: assert property (
		@(posedge clock) disable iff (!rst_n)
		wb_logic.valid |-> (logic_op != ooo_op_pkg::OP_MUL)
	);

endmodule

//--- src/reorder_buffer.sv
/*
 * reorder buffer
 */

`include "ooo_defines.svh"

module reorder_buffer (
	input  logic                          clock,
	input  logic                          rst_n,
	dispatch_if.allocator                 disp,
	writeback_if.consumer                 wb_logic,
	writeback_if.consumer                 wb_mul,
	output logic                          room,
	output logic                          commit_valid,
	output ooo_op_pkg::arch_reg_t         commit_dest,
	output ooo_op_pkg::xlen_t             commit_data,
	output ooo_status_pkg::error_status_t error_status
);

	localparam int DEPTH = `OOO_ROB_DEPTH;

	// circular pointers, wrap by width
	ooo_op_pkg::rob_tag_t   head;
	ooo_op_pkg::rob_tag_t   tail;
	logic [$clog2(DEPTH):0] count;
	// a halt or illegal op is queued
	logic                   stop_pending;
	// a halt or illegal op has committed
	logic                   halted;
	logic                   alloc;
	logic                   commit_stop;

	// per entry state
	logic [DEPTH-1:0]      ent_done;
	logic [DEPTH-1:0]      ent_halt;
	logic [DEPTH-1:0]      ent_illegal;
	ooo_op_pkg::arch_reg_t ent_dest [DEPTH];
	ooo_op_pkg::xlen_t     ent_data [DEPTH];

	assign disp.tag = tail;
	assign alloc    = disp.valid;

	// no new work once a stop op is queued or retired
	assign room = (count < DEPTH) && !stop_pending && !halted;

	////////////////////////////////////////
	// commit from the head
	////////////////////////////////////////

	assign commit_valid = (count != '0) && ent_done[head];
	assign commit_dest  = ent_dest[head];
	assign commit_data  = ent_data[head];
	assign commit_stop  = commit_valid && (ent_halt[head] || ent_illegal[head]);

	////////////////////////////////////////
	// control state
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			head         <= '0;
			tail         <= '0;
			count        <= '0;
			stop_pending <= 1'b0;
			halted       <= 1'b0;
			error_status <= ooo_status_pkg::NO_ERROR;
			ent_done     <= '0;
		end else begin
			if (commit_stop) begin
				// flush everything younger than the stop op
				head         <= head + 1'b1;
				tail         <= head + 1'b1;
				count        <= '0;
				stop_pending <= 1'b0;
				halted       <= 1'b1;
				if (ent_illegal[head]) begin
					error_status <= ooo_status_pkg::ILLEGAL_INST;
				end else begin
					error_status <= ooo_status_pkg::HALTED_ON_WFI;
				end
			end else begin
				if (alloc) begin
					tail <= tail + 1'b1;
				end
				if (commit_valid) begin
					head <= head + 1'b1;
				end
				case ({alloc, commit_valid})
					2'b10:   count <= count + 1'b1;
					2'b01:   count <= count - 1'b1;
					default: count <= count;
				endcase
				if (alloc && (disp.op == ooo_op_pkg::OP_HALT ||
						disp.op == ooo_op_pkg::OP_ILLEGAL)) begin
					stop_pending <= 1'b1;
				end
			end
			// fresh entry starts not done
			if (alloc) begin
				ent_done[tail] <= 1'b0;
			end
			// completion, any order
			if (wb_logic.valid) begin
				ent_done[wb_logic.tag] <= 1'b1;
			end
			if (wb_mul.valid) begin
				ent_done[wb_mul.tag] <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// entry payload
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (alloc) begin
			ent_dest[tail] <= disp.dest;
			ent_halt[tail] <= (disp.op == ooo_op_pkg::OP_HALT);
		end
		if (wb_logic.valid) begin
			ent_data[wb_logic.tag]    <= wb_logic.data;
			ent_illegal[wb_logic.tag] <= wb_logic.illegal;
		end
		if (wb_mul.valid) begin
			ent_data[wb_mul.tag]    <= wb_mul.data;
			ent_illegal[wb_mul.tag] <= wb_mul.illegal;
		end
	end

	// dispatch must have seen room before issuing
	a_no_alloc_full: assert property (
		@(posedge clock) disable iff (!rst_n)
		disp.valid |-> (count < DEPTH)
	);

	// writeback targets a live, pending entry
	property p_wb_live(logic v, ooo_op_pkg::rob_tag_t t);
		@(posedge clock) disable iff (!rst_n || halted)
		v |-> (ooo_op_pkg::rob_tag_t'(t - head) < count) && !ent_done[t];
	endproperty

	a_wb_logic_live: assert property (p_wb_live(wb_logic.valid, wb_logic.tag));
	a_wb_mul_live: assert property (p_wb_live(wb_mul.valid, wb_mul.tag));

	// lanes never finish the same entry together
	a_wb_no_clash: assert property (
		@(posedge clock) disable iff (!rst_n)
		!(wb_logic.valid && wb_mul.valid && (wb_logic.tag == wb_mul.tag))
	);

endmodule

//--- src/ooo_core.sv
/*
 * out-of-order back end top
 */

module ooo_core (
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic                          req,
	input  ooo_op_pkg::op_code_t          op,
	input  ooo_op_pkg::arch_reg_t         dest,
	input  ooo_op_pkg::xlen_t             src_a,
	input  ooo_op_pkg::xlen_t             src_b,
	output logic                          ack,
	output logic                          commit_valid,
	output ooo_op_pkg::arch_reg_t         commit_dest,
	output ooo_op_pkg::xlen_t             commit_data,
	output ooo_status_pkg::error_status_t error_status
);

	// rob space back to dispatch
	logic room;

	dispatch_if  disp_bus ();
	// one port per lane
	writeback_if wb_logic ();
	writeback_if wb_mul ();

	dispatch_stage dispatch_stage_inst (
		.clock (clock),
		.rst_n (rst_n),
		.req   (req),
		.op    (op),
		.dest  (dest),
		.src_a (src_a),
		.src_b (src_b),
		.room  (room),
		.ack   (ack),
		.disp  (disp_bus.issuer)
	);

	execute_stage execute_stage_inst (
		.clock    (clock),
		.rst_n    (rst_n),
		.disp     (disp_bus.lane),
		.wb_logic (wb_logic.producer),
		.wb_mul   (wb_mul.producer)
	);

	reorder_buffer reorder_buffer_inst (
		.clock        (clock),
		.rst_n        (rst_n),
		.disp         (disp_bus.allocator),
		.wb_logic     (wb_logic.consumer),
		.wb_mul       (wb_mul.consumer),
		.room         (room),
		.commit_valid (commit_valid),
		.commit_dest  (commit_dest),
		.commit_data  (commit_data),
		.error_status (error_status)
	);

endmodule

//--- bench/ooo_core_tb.sv
/*
 * ooo core testbench
 */

module ooo_core_tb;

	// well above the summed length of all tests
	localparam int TIMEOUT_CYCLES = 3000;

	logic                          clock;
	logic                          rst_n;
	logic                          req;
	ooo_op_pkg::op_code_t          op;
	ooo_op_pkg::arch_reg_t         dest;
	ooo_op_pkg::xlen_t             src_a;
	ooo_op_pkg::xlen_t             src_b;
	logic                          ack;
	logic                          commit_valid;
	ooo_op_pkg::arch_reg_t         commit_dest;
	ooo_op_pkg::xlen_t             commit_data;
	ooo_status_pkg::error_status_t error_status;

	// expected commits, oldest first
	ooo_op_pkg::arch_reg_t exp_dest_q [$];
	ooo_op_pkg::xlen_t     exp_data_q [$];

	int seed = 32'hf225;
	int error_count;
	int check_count;
	int commit_count;
	int cycle_count;

	ooo_core ooo_core_inst (
		.clock        (clock),
		.rst_n        (rst_n),
		.req          (req),
		.op           (op),
		.dest         (dest),
		.src_a        (src_a),
		.src_b        (src_b),
		.ack          (ack),
		.commit_valid (commit_valid),
		.commit_dest  (commit_dest),
		.commit_data  (commit_data),
		.error_status (error_status)
	);

	initial clock = 1'b0;
	always #10 clock = ~clock;

	////////////////////////////////////////
	// reference model and helpers
	////////////////////////////////////////

	// wrapping arithmetic, bitwise logic, truncated product, zero for halt and illegal
	function automatic ooo_op_pkg::xlen_t expected_result(input ooo_op_pkg::op_code_t o,
			input ooo_op_pkg::xlen_t a, input ooo_op_pkg::xlen_t b);
		case (o)
			ooo_op_pkg::OP_ADD: return a + b;
			ooo_op_pkg::OP_SUB: return a - b;
			ooo_op_pkg::OP_AND: return a & b;
			ooo_op_pkg::OP_OR:  return a | b;
			ooo_op_pkg::OP_XOR: return a ^ b;
			ooo_op_pkg::OP_MUL: return a * b;
			default:            return '0;
		endcase
	endfunction

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (4) @(negedge clock);
		rst_n = 1'b1;
	endtask

	// full four-phase transfer, expected commit queued first
	task automatic send_op(input ooo_op_pkg::op_code_t o, input ooo_op_pkg::arch_reg_t d,
			input ooo_op_pkg::xlen_t a, input ooo_op_pkg::xlen_t b);
		exp_dest_q.push_back(d);
		exp_data_q.push_back(expected_result(o, a, b));
		op    = o;
		dest  = d;
		src_a = a;
		src_b = b;
		req   = 1'b1;
		do @(negedge clock); while (!ack);
		req = 1'b0;
		do @(negedge clock); while (ack);
	endtask

	// request that must stay unanswered, then withdrawn
	task automatic expect_no_ack(input ooo_op_pkg::op_code_t o, input int cycles);
		logic got_ack;
		got_ack = 1'b0;
		op      = o;
		dest    = ooo_op_pkg::arch_reg_t'($random(seed));
		src_a   = $random(seed);
		src_b   = $random(seed);
		req     = 1'b1;
		repeat (cycles) begin
			@(negedge clock);
			if (ack) begin
				got_ack = 1'b1;
			end
		end
		req = 1'b0;
		@(negedge clock);
		assert (!got_ack) else begin
			$display("request after a stop op was acknowledged (time %0t)", $time);
			error_count++;
		end
	endtask

	task automatic wait_drain();
		while (exp_dest_q.size() != 0) begin
			@(negedge clock);
		end
		@(negedge clock);
	endtask

	// anything left in the queue never committed
	task automatic report_missing();
		while (exp_dest_q.size() != 0) begin
			$display("missing commit for dest %0d, data %h",
				exp_dest_q.pop_front(), exp_data_q.pop_front());
			error_count++;
		end
	endtask

	task automatic check_status(input ooo_status_pkg::error_status_t exp);
		check_count++;
		assert (error_status == exp) else begin
			$display("** Error at %0t: error_status expected %0d, got %0d",
				$time, exp, error_status);
			error_count++;
		end
	endtask

	////////////////////////////////////////
	// commit monitor
	////////////////////////////////////////

	// outputs settle after the rising edge, sample on the falling one
	always @(negedge clock) begin
		if (rst_n && commit_valid) begin
			commit_count++;
			if (exp_dest_q.size() == 0) begin
				$display("unexpected commit of dest %0d at %0t", commit_dest, $time);
				error_count++;
			end else begin
				check_count += 2;
				assert (commit_dest == exp_dest_q[0]) else begin
					$display("** Error at %0t: commit_dest expected %0d, got %0d",
						$time, exp_dest_q[0], commit_dest);
					error_count++;
				end
				assert (commit_data == exp_data_q[0]) else begin
					$display("** Error at %0t: commit_data expected %h, got %h",
						$time, exp_data_q[0], commit_data);
					error_count++;
				end
				void'(exp_dest_q.pop_front());
				void'(exp_data_q.pop_front());
			end
		end
	end

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic test_single_ops();
		send_op(ooo_op_pkg::OP_ADD, 5'd1, $random(seed), $random(seed));
		send_op(ooo_op_pkg::OP_SUB, 5'd2, $random(seed), $random(seed));
		send_op(ooo_op_pkg::OP_AND, 5'd3, $random(seed), $random(seed));
		send_op(ooo_op_pkg::OP_OR, 5'd4, $random(seed), $random(seed));
		send_op(ooo_op_pkg::OP_XOR, 5'd5, $random(seed), $random(seed));
		send_op(ooo_op_pkg::OP_MUL, 5'd6, $random(seed), $random(seed));
		wait_drain();
	endtask

	// adds finish ahead of the multiply, commit order must not change
	task automatic test_mul_order();
		send_op(ooo_op_pkg::OP_MUL, 5'd10, $random(seed), $random(seed));
		send_op(ooo_op_pkg::OP_ADD, 5'd11, $random(seed), $random(seed));
		send_op(ooo_op_pkg::OP_ADD, 5'd12, $random(seed), $random(seed));
		send_op(ooo_op_pkg::OP_ADD, 5'd13, $random(seed), $random(seed));
		wait_drain();
	endtask

	// more ops than rob entries
	task automatic test_back_to_back();
		ooo_op_pkg::op_code_t o;
		for (int i = 0; i < 20; i++) begin
			o = ooo_op_pkg::op_code_t'($unsigned($random(seed)) % 6);
			send_op(o, ooo_op_pkg::arch_reg_t'($random(seed)), $random(seed), $random(seed));
		end
		wait_drain();
	endtask

	task automatic test_halt();
		send_op(ooo_op_pkg::OP_ADD, 5'd20, $random(seed), $random(seed));
		send_op(ooo_op_pkg::OP_ADD, 5'd21, $random(seed), $random(seed));
		send_op(ooo_op_pkg::OP_HALT, 5'd22, $random(seed), $random(seed));
		expect_no_ack(ooo_op_pkg::OP_ADD, 50);
		report_missing();
		check_status(ooo_status_pkg::HALTED_ON_WFI);
		apply_reset();
	endtask

	task automatic test_illegal();
		int commits_seen;
		check_status(ooo_status_pkg::NO_ERROR);
		send_op(ooo_op_pkg::OP_ILLEGAL, 5'd9, $random(seed), $random(seed));
		expect_no_ack(ooo_op_pkg::OP_ADD, 30);
		report_missing();
		check_status(ooo_status_pkg::ILLEGAL_INST);
		commits_seen = commit_count;
		repeat (10) @(negedge clock);
		assert (commit_count == commits_seen) else begin
			$display("commit seen after the illegal op retired (time %0t)", $time);
			error_count++;
		end
	endtask

	////////////////////////////////////////
	// sequence and summary
	////////////////////////////////////////

	initial begin
		rst_n = 1'b0;
		req   = 1'b0;
		op    = ooo_op_pkg::OP_ADD;
		dest  = '0;
		src_a = '0;
		src_b = '0;
		apply_reset();
		test_single_ops();
		test_mul_order();
		test_back_to_back();
		test_halt();
		test_illegal();
		report_missing();
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// hang guard
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("checks: %0d, errors: %0d", check_count, error_count + 1);
			$display("Test failed");
			$finish;
		end
	end

endmodule

//--- sim.f
+incdir+include
src/ooo_op_pkg.sv
src/ooo_status_pkg.sv
src/dispatch_if.sv
src/writeback_if.sv
src/dispatch_stage.sv
src/execute_stage.sv
src/reorder_buffer.sv
src/ooo_core.sv
bench/ooo_core_tb.sv
